/* hdl/lsu_pkg.sv */
package lsu_pkg;

  localparam int xlen = 32;
  localparam int strb_w = xlen / 8;

  // funct3 encodings of the load instructions
  typedef enum logic [2:0] {
    ld_b  = 3'b000,
    ld_h  = 3'b001,
    ld_w  = 3'b010,
    ld_bu = 3'b100,
    ld_hu = 3'b101
  } load_func_t;

  // funct3 encodings of the store instructions
  typedef enum logic [2:0] {
    st_b = 3'b000,
    st_h = 3'b001,
    st_w = 3'b010
  } store_func_t;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } resp_t;

endpackage

/* hdl/mem_req_if.sv */
`timescale 1ns/1ps

// core side request into the load/store unit
interface mem_req_if import lsu_pkg::*; #(
  parameter type func_t = logic [2:0]
);

  logic            valid;
  logic            ready;
  logic [xlen-1:0] addr;
  func_t           func;
  logic [xlen-1:0] data;

  modport core (
    output valid, addr, func, data,
    input  ready
  );

  modport unit (
    input  valid, addr, func, data,
    output ready
  );

endinterface

/* hdl/axi_r_if.sv */
`timescale 1ns/1ps

interface axi_r_if import lsu_pkg::*;;

  logic            arvalid;
  logic            arready;
  logic [xlen-1:0] araddr;
  logic            rvalid;
  logic            rready;
  logic [xlen-1:0] rdata;
  resp_t           rresp;

  modport master (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata, rresp
  );

endinterface

/* hdl/axi_w_if.sv */
`timescale 1ns/1ps

interface axi_w_if import lsu_pkg::*;;

  logic              awvalid;
  logic              awready;
  logic [xlen-1:0]   awaddr;
  logic              wvalid;
  logic              wready;
  logic [xlen-1:0]   wdata;
  logic [strb_w-1:0] wstrb;
  logic              bvalid;
  logic              bready;
  resp_t             bresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  awready, wready, bvalid, bresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output awready, wready, bvalid, bresp
  );

endinterface

/* hdl/lsu.sv */
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  mem_req_if.unit         ld_req,
  mem_req_if.unit         st_req,
  output logic [xlen-1:0] rdata,
  output logic            rdata_valid,
  input  logic            rdata_ready,
  output logic            store_done,
  input  logic            store_done_ready,
  axi_r_if.master         ram_r,
  axi_w_if.master         ram_w
);

  logic              ld_fire;
  logic              ar_free;
  logic              ld_sk_full;
  logic              ld_sk_nxt;
  logic [xlen-1:0]   ld_sk_addr;
  load_func_t        ld_sk_func;
  load_func_t        ar_func;
  load_func_t        rd_func;
  logic [1:0]        rd_align;

  logic              r_fire;
  logic              out_free;
  logic              rd_sk_full;
  logic              rd_sk_nxt;
  logic [xlen-1:0]   rd_sk_data;
  logic [xlen-1:0]   rd_word;

  logic              st_fire;
  logic              aw_free;
  logic              w_free;
  logic              aw_flag;
  logic              w_flag;
  logic              aw_nxt;
  logic              w_nxt;
  logic [xlen-1:0]   sk_awaddr;
  logic [xlen-1:0]   sk_wdata;
  logic [strb_w-1:0] sk_wstrb;
  logic [strb_w-1:0] st_mask;
  logic [strb_w-1:0] st_strb;
  logic [xlen-1:0]   st_wdata;

  logic              b_fire;
  logic              done_nxt;
  logic [1:0]        wr_open;

  function automatic logic [xlen-1:0] load_format(input logic [xlen-1:0] word,
                                                  input logic [1:0]      align,
                                                  input load_func_t      func);
    logic [xlen-1:0] sh;
    sh = word >> {align, 3'b000};
    case (func)
      ld_b:    return {{(xlen - 8){sh[7]}}, sh[7:0]};
      ld_bu:   return {{(xlen - 8){1'b0}}, sh[7:0]};
      ld_h:    return {{(xlen - 16){sh[15]}}, sh[15:0]};
      ld_hu:   return {{(xlen - 16){1'b0}}, sh[15:0]};
      default: return sh;
    endcase
  endfunction

  assign ld_fire   = ld_req.valid && ld_req.ready;
  assign ar_free   = !ram_r.arvalid || ram_r.arready;
  assign ld_sk_nxt = ld_sk_full ? !ar_free : (ld_fire && !ar_free);

  assign r_fire    = ram_r.rvalid && ram_r.rready;
  assign out_free  = !rdata_valid || rdata_ready;
  assign rd_sk_nxt = rd_sk_full ? !out_free : (r_fire && !out_free);
  assign rd_word   = load_format(ram_r.rdata, rd_align, rd_func);

  // read address, with a one-entry skid in front of it
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ld_req.ready  <= 1'b0;
      ram_r.arvalid <= 1'b0;
      ld_sk_full    <= 1'b0;
    end else begin
      ld_req.ready <= !ld_sk_nxt;
      ld_sk_full   <= ld_sk_nxt;
      if (ram_r.arvalid && ram_r.arready) begin
        ram_r.arvalid <= 1'b0;
        rd_align      <= ram_r.araddr[1:0];
        rd_func       <= ar_func;
      end
      if (ld_sk_full && ar_free) begin
        ram_r.arvalid <= 1'b1;
        ram_r.araddr  <= ld_sk_addr;
        ar_func       <= ld_sk_func;
      end else if (ld_fire && ar_free) begin
        ram_r.arvalid <= 1'b1;
        ram_r.araddr  <= ld_req.addr;
        ar_func       <= ld_req.func;
      end else if (ld_fire) begin
        ld_sk_addr <= ld_req.addr;
        ld_sk_func <= ld_req.func;
      end
    end
  end

  // load result, skid holds a beat while rdata is stalled
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ram_r.rready <= 1'b0;
      rdata_valid  <= 1'b0;
      rd_sk_full   <= 1'b0;
    end else begin
      ram_r.rready <= !rd_sk_nxt;
      rd_sk_full   <= rd_sk_nxt;
      if (rdata_valid && rdata_ready) begin
        rdata_valid <= 1'b0;
      end
      if (rd_sk_full && out_free) begin
        rdata       <= rd_sk_data;
        rdata_valid <= 1'b1;
      end else if (r_fire && out_free) begin
        rdata       <= rd_word;
        rdata_valid <= 1'b1;
      end else if (r_fire) begin
        rd_sk_data <= rd_word;
      end
    end
  end

  always_comb begin
    case (st_req.func)
      st_b:    st_mask = strb_w'(1);
      st_h:    st_mask = strb_w'(3);
      default: st_mask = '1;
    endcase
  end

  assign st_strb  = st_mask << st_req.addr[1:0];
  assign st_wdata = st_req.data << {st_req.addr[1:0], 3'b000};

  assign st_fire = st_req.valid && st_req.ready;
  assign aw_free = !ram_w.awvalid || ram_w.awready;
  assign w_free  = !ram_w.wvalid || ram_w.wready;
  assign aw_nxt  = aw_flag ? !aw_free : (st_fire && !aw_free);
  assign w_nxt   = w_flag ? !w_free : (st_fire && !w_free);

  // address and data channels each keep their own skid flag
  always_ff @(posedge clk) begin
    if (!rstn) begin
      st_req.ready  <= 1'b0;
      ram_w.awvalid <= 1'b0;
      ram_w.wvalid  <= 1'b0;
      aw_flag       <= 1'b0;
      w_flag        <= 1'b0;
    end else begin
      st_req.ready <= !(aw_nxt || w_nxt);
      aw_flag      <= aw_nxt;
      w_flag       <= w_nxt;
      if (ram_w.awvalid && ram_w.awready) begin
        ram_w.awvalid <= 1'b0;
      end
      if (ram_w.wvalid && ram_w.wready) begin
        ram_w.wvalid <= 1'b0;
      end
      if (aw_flag && aw_free) begin
        ram_w.awvalid <= 1'b1;
        ram_w.awaddr  <= sk_awaddr;
      end else if (st_fire && aw_free) begin
        ram_w.awvalid <= 1'b1;
        ram_w.awaddr  <= st_req.addr;
      end else if (st_fire) begin
        sk_awaddr <= st_req.addr;
      end
      if (w_flag && w_free) begin
        ram_w.wvalid <= 1'b1;
        ram_w.wdata  <= sk_wdata;
        ram_w.wstrb  <= sk_wstrb;
      end else if (st_fire && w_free) begin
        ram_w.wvalid <= 1'b1;
        ram_w.wdata  <= st_wdata;
        ram_w.wstrb  <= st_strb;
      end else if (st_fire) begin
        sk_wdata <= st_wdata;
        sk_wstrb <= st_strb;
      end
    end
  end

  assign b_fire   = ram_w.bvalid && ram_w.bready;
  assign done_nxt = b_fire || (store_done && !store_done_ready);

  // bready stays low while a completion is still unclaimed
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ram_w.bready <= 1'b0;
      store_done   <= 1'b0;
    end else begin
      ram_w.bready <= !done_nxt;
      store_done   <= done_nxt;
    end
  end

  // writes sent to memory and not yet answered
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_open <= 2'd0;
    end else begin
      wr_open <= wr_open + 2'(ram_w.awvalid && ram_w.awready) - 2'(b_fire);
    end
  end

  a_araddr_stable: assert property (@(posedge clk) disable iff (!rstn)
    ram_r.arvalid && !ram_r.arready |=> ram_r.arvalid && $stable(ram_r.araddr))
    else $error("araddr changed while arvalid waited");

  a_done_after_b: assert property (@(posedge clk) disable iff (!rstn)
    $rose(store_done) |-> $past(b_fire && wr_open != 2'd0))
    else $error("store_done raised without a write response");

endmodule

/* hdl/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram import lsu_pkg::*; #(
  parameter int mem_words = 1024
) (
  input  logic    clk,
  input  logic    rstn,
  axi_r_if.slave  ram_r,
  axi_w_if.slave  ram_w
);

  localparam int idx_w = $clog2(mem_words);

  logic [xlen-1:0]  mem [mem_words];
  logic             run;
  logic             rd_pend;
  logic [idx_w-1:0] rd_idx;
  logic             ar_fire;
  logic             wr_pend;
  logic             wr_idle;
  logic             wr_fire;
  logic [idx_w-1:0] wr_idx;

  assign ram_r.arready = run && !rd_pend && !ram_r.rvalid;
  assign ar_fire       = ram_r.arvalid && ram_r.arready;

  // address and data are taken together in one beat
  assign wr_idle       = run && !wr_pend && !ram_w.bvalid;
  assign ram_w.awready = wr_idle && ram_w.wvalid;
  assign ram_w.wready  = wr_idle && ram_w.awvalid;
  assign wr_fire       = ram_w.awvalid && ram_w.awready;
  assign wr_idx        = ram_w.awaddr[idx_w+1:2];

  assign ram_r.rresp = okay;
  assign ram_w.bresp = okay;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      run          <= 1'b0;
      rd_pend      <= 1'b0;
      ram_r.rvalid <= 1'b0;
      wr_pend      <= 1'b0;
      ram_w.bvalid <= 1'b0;
    end else begin
      run     <= 1'b1;
      rd_pend <= ar_fire;
      wr_pend <= wr_fire;
      if (rd_pend) begin
        ram_r.rvalid <= 1'b1;
      end else if (ram_r.rvalid && ram_r.rready) begin
        ram_r.rvalid <= 1'b0;
      end
      if (wr_pend) begin
        ram_w.bvalid <= 1'b1;
      end else if (ram_w.bvalid && ram_w.bready) begin
        ram_w.bvalid <= 1'b0;
      end
    end
  end

  // word array, only strobed byte lanes are written
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rd_idx <= ram_r.araddr[idx_w+1:2];
    end
    if (rd_pend) begin
      ram_r.rdata <= mem[rd_idx];
    end
    if (wr_fire) begin
      for (int b = 0; b < strb_w; b++) begin
        if (ram_w.wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= ram_w.wdata[8*b +: 8];
        end
      end
    end
  end

  a_wstrb_nonzero: assert property (@(posedge clk) disable iff (!rstn)
    wr_fire |-> ram_w.wstrb != '0)
    else $error("write accepted with an empty strobe");

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int mem_words = 1024
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            load_valid,
  output logic            load_ready,
  input  logic [xlen-1:0] load_addr,
  input  load_func_t      load_func,
  output logic [xlen-1:0] rdata,
  output logic            rdata_valid,
  input  logic            rdata_ready,
  input  logic            store_valid,
  output logic            store_ready,
  input  logic [xlen-1:0] store_addr,
  input  store_func_t     store_func,
  input  logic [xlen-1:0] store_data,
  output logic            store_done,
  input  logic            store_done_ready
);

  mem_req_if #(.func_t(load_func_t))  ld_req ();
  mem_req_if #(.func_t(store_func_t)) st_req ();
  axi_r_if                            ram_r ();
  axi_w_if                            ram_w ();

  assign ld_req.valid = load_valid;
  assign ld_req.addr  = load_addr;
  assign ld_req.func  = load_func;
  // loads carry no data
  assign ld_req.data  = '0;
  assign load_ready   = ld_req.ready;

  assign st_req.valid = store_valid;
  assign st_req.addr  = store_addr;
  assign st_req.func  = store_func;
  assign st_req.data  = store_data;
  assign store_ready  = st_req.ready;

  lsu lsu_i (
    .clk              (clk),
    .rstn             (rstn),
    .ld_req           (ld_req.unit),
    .st_req           (st_req.unit),
    .rdata            (rdata),
    .rdata_valid      (rdata_valid),
    .rdata_ready      (rdata_ready),
    .store_done       (store_done),
    .store_done_ready (store_done_ready),
    .ram_r            (ram_r.master),
    .ram_w            (ram_w.master)
  );

  axi_sram #(.mem_words(mem_words)) axi_sram_i (
    .clk   (clk),
    .rstn  (rstn),
    .ram_r (ram_r.slave),
    .ram_w (ram_w.slave)
  );

endmodule

/* sim/tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*;;

  localparam int mem_words = 1024;
  localparam int n_tests = 33;
  localparam int timeout_ns = (n_tests * 40 + 4) * 10;
  localparam bit st = 1'b1;
  localparam bit ld = 1'b0;

  typedef struct packed {
    bit              is_st;
    logic [2:0]      func;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    logic [xlen-1:0] exp;
  } test_t;

  // kind, funct3, address, store data, expected load result
  localparam test_t tests [n_tests] = '{
    '{st, st_w,  32'h0000_0100, 32'h1234_5678, 32'h0000_0000},
    '{ld, ld_w,  32'h0000_0100, 32'h0000_0000, 32'h1234_5678},
    '{st, st_w,  32'h0000_0104, 32'h0000_0000, 32'h0000_0000},
    '{st, st_b,  32'h0000_0104, 32'hFFFF_FF11, 32'h0000_0000},
    '{ld, ld_w,  32'h0000_0104, 32'h0000_0000, 32'h0000_0011},
    '{st, st_b,  32'h0000_0105, 32'hABCD_EF22, 32'h0000_0000},
    '{st, st_b,  32'h0000_0106, 32'h1234_5633, 32'h0000_0000},
    '{st, st_b,  32'h0000_0107, 32'h0000_00C4, 32'h0000_0000},
    '{ld, ld_w,  32'h0000_0104, 32'h0000_0000, 32'hC433_2211},
    '{st, st_w,  32'h0000_0108, 32'h95FE_7F81, 32'h0000_0000},
    '{ld, ld_b,  32'h0000_0108, 32'h0000_0000, 32'hFFFF_FF81},
    '{ld, ld_bu, 32'h0000_0108, 32'h0000_0000, 32'h0000_0081},
    '{ld, ld_b,  32'h0000_0109, 32'h0000_0000, 32'h0000_007F},
    '{ld, ld_bu, 32'h0000_0109, 32'h0000_0000, 32'h0000_007F},
    '{ld, ld_b,  32'h0000_010A, 32'h0000_0000, 32'hFFFF_FFFE},
    '{ld, ld_bu, 32'h0000_010A, 32'h0000_0000, 32'h0000_00FE},
    '{ld, ld_b,  32'h0000_010B, 32'h0000_0000, 32'hFFFF_FF95},
    '{ld, ld_bu, 32'h0000_010B, 32'h0000_0000, 32'h0000_0095},
    '{ld, ld_h,  32'h0000_0108, 32'h0000_0000, 32'h0000_7F81},
    '{ld, ld_hu, 32'h0000_0108, 32'h0000_0000, 32'h0000_7F81},
    '{ld, ld_h,  32'h0000_010A, 32'h0000_0000, 32'hFFFF_95FE},
    '{ld, ld_hu, 32'h0000_010A, 32'h0000_0000, 32'h0000_95FE},
    '{st, st_w,  32'h0000_010C, 32'h0000_0000, 32'h0000_0000},
    '{st, st_h,  32'h0000_010E, 32'hFFFF_8001, 32'h0000_0000},
    '{st, st_h,  32'h0000_010C, 32'h0000_7FFE, 32'h0000_0000},
    '{ld, ld_w,  32'h0000_010C, 32'h0000_0000, 32'h8001_7FFE},
    '{ld, ld_h,  32'h0000_010E, 32'h0000_0000, 32'hFFFF_8001},
    '{ld, ld_hu, 32'h0000_010C, 32'h0000_0000, 32'h0000_7FFE},
    '{st, st_w,  32'h0000_0100, 32'hDEAD_BEEF, 32'h0000_0000},
    '{ld, ld_w,  32'h0000_0100, 32'h0000_0000, 32'hDEAD_BEEF},
    '{ld, ld_w,  32'h0000_0108, 32'h0000_0000, 32'h95FE_7F81},
    '{ld, ld_b,  32'h0000_0104, 32'h0000_0000, 32'h0000_0011},
    '{ld, ld_b,  32'h0000_0107, 32'h0000_0000, 32'hFFFF_FFC4}
  };

  logic            clk;
  logic            rstn;
  logic            load_valid;
  logic            load_ready;
  logic [xlen-1:0] load_addr;
  load_func_t      load_func;
  logic [xlen-1:0] rdata;
  logic            rdata_valid;
  logic            rdata_ready;
  logic            store_valid;
  logic            store_ready;
  logic [xlen-1:0] store_addr;
  store_func_t     store_func;
  logic [xlen-1:0] store_data;
  logic            store_done;
  logic            store_done_ready;

  logic [7:0]      ref_mem [4*mem_words];
  logic [xlen-1:0] exp_q [$];
  int              st_issued;
  int              done_cnt;
  integer          seed;

  lsu_top #(.mem_words(mem_words)) lsu_top_i (
    .clk              (clk),
    .rstn             (rstn),
    .load_valid       (load_valid),
    .load_ready       (load_ready),
    .load_addr        (load_addr),
    .load_func        (load_func),
    .rdata            (rdata),
    .rdata_valid      (rdata_valid),
    .rdata_ready      (rdata_ready),
    .store_valid      (store_valid),
    .store_ready      (store_ready),
    .store_addr       (store_addr),
    .store_func       (store_func),
    .store_data       (store_data),
    .store_done       (store_done),
    .store_done_ready (store_done_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_load(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH rdata: got 0x%08h expected 0x%08h", got, exp));
    end
  endtask

  task automatic check_store_done(input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("MISMATCH store_done count: got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // little-endian byte model of the memory
  function automatic logic [xlen-1:0] model_load(input logic [xlen-1:0] addr,
                                                 input load_func_t func);
    int              a;
    logic [xlen-1:0] w;
    a = int'(addr) % (4 * mem_words);
    w = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
    case (func)
      ld_b:    return {{(xlen - 8){w[7]}}, w[7:0]};
      ld_bu:   return {{(xlen - 8){1'b0}}, w[7:0]};
      ld_h:    return {{(xlen - 16){w[15]}}, w[15:0]};
      ld_hu:   return {{(xlen - 16){1'b0}}, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic model_store(input logic [xlen-1:0] addr, input store_func_t func,
                             input logic [xlen-1:0] data);
    int a;
    int nbytes;
    a = int'(addr) % (4 * mem_words);
    nbytes = (func == st_b) ? 1 : (func == st_h) ? 2 : 4;
    for (int k = 0; k < nbytes; k++) begin
      ref_mem[a+k] = data[8*k +: 8];
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_load(input logic [xlen-1:0] addr, input load_func_t func);
    load_valid = 1'b1;
    load_addr  = addr;
    load_func  = func;
    while (!load_ready) @(negedge clk);
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic send_store(input logic [xlen-1:0] addr, input store_func_t func,
                            input logic [xlen-1:0] data);
    store_valid = 1'b1;
    store_addr  = addr;
    store_func  = func;
    store_data  = data;
    while (!store_ready) @(negedge clk);
    @(negedge clk);
    store_valid = 1'b0;
  endtask

  task automatic wait_loads_drained();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic wait_stores_done();
    while (done_cnt < st_issued) @(negedge clk);
    check_store_done(done_cnt, st_issued);
  endtask

  task automatic run_entry(input int idx);
    test_t           t;
    logic [xlen-1:0] model;
    t = tests[idx];
    if (t.is_st) begin
      wait_loads_drained();
      model_store(t.addr, store_func_t'(t.func), t.data);
      send_store(t.addr, store_func_t'(t.func), t.data);
      st_issued++;
    end else begin
      wait_stores_done();
      model = model_load(t.addr, load_func_t'(t.func));
      if (model !== t.exp) begin
        abort_run($sformatf("table entry %0d disagrees with the reference memory", idx));
      end
      exp_q.push_back(t.exp);
      send_load(t.addr, load_func_t'(t.func));
    end
  endtask

  // results must come back in request order
  always @(posedge clk) begin
    if (rstn && rdata_valid && rdata_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("load result arrived with no load outstanding");
      end
      check_load(rdata, exp_q.pop_front());
    end
    if (rstn && store_done && store_done_ready) begin
      done_cnt++;
    end
  end

  // random back-pressure stretches on both result outputs
  initial begin
    seed = 58;
    rdata_ready = 1'b0;
    store_done_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (($random(seed) & 3) == 0) rdata_ready = !rdata_ready;
      if (($random(seed) & 3) == 0) store_done_ready = !store_done_ready;
    end
  end

  initial begin
    #(timeout_ns);
    abort_run("timeout: the table did not complete in the allowed time");
  end

  initial begin
    rstn        = 1'b0;
    load_valid  = 1'b0;
    load_addr   = '0;
    load_func   = ld_w;
    store_valid = 1'b0;
    store_addr  = '0;
    store_func  = st_w;
    store_data  = '0;
    st_issued   = 0;
    done_cnt    = 0;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_flag("load_ready", load_ready, 1'b0);
      check_flag("store_ready", store_ready, 1'b0);
    end
    rstn = 1'b1;
    @(negedge clk);
    check_flag("load_ready", load_ready, 1'b1);
    check_flag("store_ready", store_ready, 1'b1);
    // idle outputs stay quiet before any request
    repeat (3) begin
      check_flag("rdata_valid", rdata_valid, 1'b0);
      check_flag("store_done", store_done, 1'b0);
      @(negedge clk);
    end
    for (int i = 0; i < n_tests; i++) begin
      run_entry(i);
    end
    wait_loads_drained();
    wait_stores_done();
    repeat (5) @(negedge clk);
    check_store_done(done_cnt, st_issued);
    if (rdata_valid || store_done) begin
      abort_run("a result output is still valid after the last request");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

/* filelist.f */
hdl/lsu_pkg.sv
hdl/mem_req_if.sv
hdl/axi_r_if.sv
hdl/axi_w_if.sv
hdl/lsu.sv
hdl/axi_sram.sv
hdl/lsu_top.sv
sim/tb_lsu_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_lsu_top
FILELIST  := filelist.f
BUILD     := obj_dir
LOG       := sim.log

SIM  := $(BUILD)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
